//--- source/emesh_pkg.sv
// Shared eMesh types and constants; CHIP_ID marks the config region, FIFO_DEPTH must be a power of 2
package emesh_pkg;

   // ####################################################################
   // Widths
   // ####################################################################

   // Address and data width of the mesh
   localparam int AW = 32;

   // Chip ID compared against the top 12 bits of dstaddr
   localparam int ID_W = 12;
   localparam logic [ID_W-1:0] CHIP_ID = 12'h810;

   // ####################################################################
   // Channel FIFOs
   // ####################################################################

   // Entries per channel FIFO
   localparam int FIFO_DEPTH = 4;

   // Pointer width, one extra bit on the count to tell full from empty
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

   // ####################################################################
   // Configuration registers
   // ####################################################################

   // Number of config words
   localparam int CFG_REGS = 4;

   // Word select, taken from dstaddr starting at bit 2
   localparam int CFG_IDX_W = $clog2(CFG_REGS);
   localparam int CFG_IDX_LSB = 2;

   // One config word
   typedef logic [AW-1:0] cfg_word_t;

   // ####################################################################
   // Packet
   // ####################################################################

   // Field order follows the eMesh packet layout, MSB first
   // 1 + 2 + 5 + 3 * AW = 104 bits
   typedef struct packed
   {
      // Write when set, read request otherwise
      logic          write;
      // Transfer size code
      logic [1:0]    datamode;
      // Routing and special control bits
      logic [4:0]    ctrlmode;
      // Destination, top ID_W bits select the chip
      logic [AW-1:0] dstaddr;
      // Write data, or return address on a read
      logic [AW-1:0] data;
      // Source address for read responses
      logic [AW-1:0] srcaddr;
   } emesh_packet_t;

endpackage

//--- source/etx_fifo.sv
// First-word fall-through FIFO; a push into a full FIFO is taken only when a pop happens in the same cycle
`timescale 1ns/1ps

module etx_fifo
  #(
   parameter type payload_t = logic
   )
  (
   input  logic     clk,
   input  logic     nreset,
   // Source side
   input  logic     in_access,
   input  payload_t in_packet,
   output logic     in_wait,
   // Arbiter side
   output logic     out_access,
   output payload_t out_packet,
   input  logic     out_wait
   );

   import emesh_pkg::*;

   // Storage, no reset on the payload
   payload_t mem [FIFO_DEPTH];

   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;

   logic full;
   logic push;
   logic pop;

   // ####################################################################
   // Flags and handshake
   // ####################################################################

   assign full = (count == FIFO_CNT_W'(FIFO_DEPTH));

   // Head is valid whenever something is stored
   assign out_access = (count != '0);
   assign out_packet = mem[rd_ptr];

   // Arbiter takes the head when it does not hold us off
   assign pop = out_access & ~out_wait;

   // Full blocks the source unless the head leaves this cycle
   assign in_wait = full & ~pop;
   assign push = in_access & ~in_wait;

   // ####################################################################
   // Pointers and count
   // ####################################################################

   // Pointers wrap naturally, depth is a power of 2
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Count only moves on a lone push or lone pop
         if (push & ~pop)
            count <= count + 1'b1;
         else if (pop & ~push)
            count <= count - 1'b1;
      end
   end

   // Write port
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_packet;
   end

   // ####################################################################
   // Checks
   // ####################################################################

   // Occupancy stays between empty and FIFO_DEPTH, a wrap means overflow or underflow
   a_count_range : assert property (@(posedge clk) disable iff (!nreset)
      count <= FIFO_CNT_W'(FIFO_DEPTH));

   // Pointer distance agrees with the count
   a_ptr_count : assert property (@(posedge clk) disable iff (!nreset)
      (wr_ptr - rd_ptr) == count[FIFO_PTR_W-1:0]);

endmodule

//--- source/etx_arbiter.sv
// Fixed priority rr > wr > rd with no fairness; config-region packets go to cfg_access, not the link
`timescale 1ns/1ps

module etx_arbiter
  (
   input  logic                     clk,
   input  logic                     nreset,
   // Host writes
   input  logic                     txwr_access,
   input  emesh_pkg::emesh_packet_t txwr_packet,
   output logic                     txwr_wait,
   // Host read requests
   input  logic                     txrd_access,
   input  emesh_pkg::emesh_packet_t txrd_packet,
   output logic                     txrd_wait,
   // Read responses
   input  logic                     txrr_access,
   input  emesh_pkg::emesh_packet_t txrr_packet,
   output logic                     txrr_wait,
   // Stall inputs
   input  logic                     etx_wait,
   input  logic                     cfg_wait,
   // Registered outputs, packet shared by link and config
   output logic                     etx_access,
   output logic                     cfg_access,
   output emesh_pkg::emesh_packet_t etx_packet
   );

   import emesh_pkg::*;

   logic          txrr_grant;
   logic          txwr_grant;
   logic          txrd_grant;
   logic [2:0]    grants;
   logic [2:0]    pops;
   logic          all_wait;
   logic          access_in;
   logic          cfg_match;
   emesh_packet_t sel_packet;

   // ####################################################################
   // Fixed priority grant
   // ####################################################################

   // Read responses win, then writes, then read requests
   assign txrr_grant = txrr_access;
   assign txwr_grant = txwr_access & ~txrr_access;
   assign txrd_grant = txrd_access & ~txrr_access & ~txwr_access;

   assign grants = {txrd_grant, txwr_grant, txrr_grant};

   // Granted packet
   always_comb
   begin
      sel_packet = txrd_packet;
      if (txrr_grant)
         sel_packet = txrr_packet;
      else if (txwr_grant)
         sel_packet = txwr_packet;
   end

   // ####################################################################
   // Pushback
   // ####################################################################

   // Either the link or the config block can stall everything
   assign all_wait = etx_wait | cfg_wait;

   assign txrr_wait = all_wait;

   // Lower priority sources also wait on any higher one
   assign txwr_wait = all_wait | txrr_access;
   assign txrd_wait = all_wait | txrr_access | txwr_access;

   // Channels whose FIFO pops this cycle
   assign pops = {txrd_access & ~txrd_wait, txwr_access & ~txwr_wait,
                  txrr_access & ~txrr_wait};

   // Only the granted channel is ever unblocked
   assign access_in = |grants & ~all_wait;

   // ####################################################################
   // Output stage
   // ####################################################################

   // Config region is the chip's own ID in the top address bits
   assign cfg_match = (sel_packet.dstaddr[AW-1 -: ID_W] == CHIP_ID);

   // Access flags hold while stalled
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         etx_access <= 1'b0;
         cfg_access <= 1'b0;
      end
      else if (!all_wait)
      begin
         etx_access <= access_in & ~cfg_match;
         cfg_access <= access_in & cfg_match;
      end
   end

   // Payload register, loaded only on a real transfer
   always_ff @(posedge clk)
   begin
      if (access_in)
         etx_packet <= sel_packet;
   end

   // ####################################################################
   // Checks
   // ####################################################################

   // Wait levels free at most one FIFO, and only the granted one
   a_pop_granted : assert property (@(posedge clk) disable iff (!nreset)
      $onehot0(pops) && (pops == (grants & {3{~all_wait}})));

endmodule

//--- source/etx_cfg_regs.sv
// Config words written by config-region writes; reads are dropped and no response is generated
`timescale 1ns/1ps

module etx_cfg_regs
  (
   input  logic                                       clk,
   input  logic                                       nreset,
   // Config access from the arbiter
   input  logic                                       cfg_access,
   input  emesh_pkg::emesh_packet_t                   cfg_packet,
   output logic                                       cfg_wait,
   // Register contents
   output emesh_pkg::cfg_word_t [emesh_pkg::CFG_REGS-1:0] cfg_words
   );

   import emesh_pkg::*;

   logic                 accept;
   logic [CFG_IDX_W-1:0] sel;

   // ####################################################################
   // Access decode
   // ####################################################################

   // An access seen during the busy cycle is held off, not taken
   assign accept = cfg_access & ~cfg_wait;

   // Word select from the low address bits
   assign sel = cfg_packet.dstaddr[CFG_IDX_LSB +: CFG_IDX_W];

   // One busy cycle after every accepted access, write or read
   always_ff @(posedge clk)
   begin
      if (!nreset)
         cfg_wait <= 1'b0;
      else
         cfg_wait <= accept;
   end

   // ####################################################################
   // Register file
   // ####################################################################

   // Words come up zero
   always_ff @(posedge clk)
   begin
      if (!nreset)
         cfg_words <= '0;
      // Reads fall through here and are discarded
      else if (accept && cfg_packet.write)
         cfg_words[sel] <= cfg_packet.data;
   end

   // ####################################################################
   // Checks
   // ####################################################################

   // Arbiter must hold an access that meets the busy cycle
   // Packet and strobe both stay unchanged into the next cycle
   a_held_while_busy : assert property (@(posedge clk) disable iff (!nreset)
      (cfg_access && cfg_wait) |=> (cfg_access && $stable(cfg_packet)));

endmodule

//--- source/etx_top.sv
// Transmit top; three source FIFOs feed one fixed-priority link, config-region packets stay on chip
`timescale 1ns/1ps

module etx_top
  (
   input  logic                                       clk,
   input  logic                                       nreset,
   // Host writes
   input  logic                                       txwr_access,
   input  emesh_pkg::emesh_packet_t                   txwr_packet,
   output logic                                       txwr_wait,
   // Host read requests
   input  logic                                       txrd_access,
   input  emesh_pkg::emesh_packet_t                   txrd_packet,
   output logic                                       txrd_wait,
   // Read responses
   input  logic                                       txrr_access,
   input  emesh_pkg::emesh_packet_t                   txrr_packet,
   output logic                                       txrr_wait,
   // Link
   input  logic                                       etx_wait,
   output logic                                       etx_access,
   output emesh_pkg::emesh_packet_t                   etx_packet,
   // Config register contents
   output emesh_pkg::cfg_word_t [emesh_pkg::CFG_REGS-1:0] cfg_words
   );

   import emesh_pkg::*;

   // FIFO heads toward the arbiter
   logic          wr_access;
   emesh_packet_t wr_packet;
   logic          wr_wait;
   logic          rd_access;
   emesh_packet_t rd_packet;
   logic          rd_wait;
   logic          rr_access;
   emesh_packet_t rr_packet;
   logic          rr_wait;

   // Config path
   logic          cfg_access;
   logic          cfg_wait;

   // ####################################################################
   // Channel FIFOs
   // ####################################################################

   etx_fifo #(.payload_t(emesh_packet_t)) i_txwr_fifo
     (.clk(clk), .nreset(nreset),
      .in_access(txwr_access), .in_packet(txwr_packet), .in_wait(txwr_wait),
      .out_access(wr_access), .out_packet(wr_packet), .out_wait(wr_wait));

   etx_fifo #(.payload_t(emesh_packet_t)) i_txrd_fifo
     (.clk(clk), .nreset(nreset),
      .in_access(txrd_access), .in_packet(txrd_packet), .in_wait(txrd_wait),
      .out_access(rd_access), .out_packet(rd_packet), .out_wait(rd_wait));

   etx_fifo #(.payload_t(emesh_packet_t)) i_txrr_fifo
     (.clk(clk), .nreset(nreset),
      .in_access(txrr_access), .in_packet(txrr_packet), .in_wait(txrr_wait),
      .out_access(rr_access), .out_packet(rr_packet), .out_wait(rr_wait));

   // ####################################################################
   // Arbiter and config block
   // ####################################################################

   etx_arbiter i_etx_arbiter
     (.clk(clk), .nreset(nreset),
      .txwr_access(wr_access), .txwr_packet(wr_packet), .txwr_wait(wr_wait),
      .txrd_access(rd_access), .txrd_packet(rd_packet), .txrd_wait(rd_wait),
      .txrr_access(rr_access), .txrr_packet(rr_packet), .txrr_wait(rr_wait),
      .etx_wait(etx_wait), .cfg_wait(cfg_wait),
      .etx_access(etx_access), .cfg_access(cfg_access), .etx_packet(etx_packet));

   // Shares the arbiter's output packet register
   etx_cfg_regs i_etx_cfg_regs
     (.clk(clk), .nreset(nreset),
      .cfg_access(cfg_access), .cfg_packet(etx_packet), .cfg_wait(cfg_wait),
      .cfg_words(cfg_words));

endmodule

//--- tests/etx_top_tb.sv
// Config traffic runs only with the link wait off since cfg_wait is internal; srcaddr[1:0] tags the channel
`timescale 1ns/1ps

module etx_top_tb;

   import emesh_pkg::*;

   localparam int TIMEOUT    = 200;
   localparam int CFG_SETTLE = 4;
   localparam int WAIT_OFF   = 0;
   localparam int WAIT_RAND  = 1;
   localparam int WAIT_HIGH  = 2;

   // Channel tags, also the low bits of srcaddr
   localparam logic [1:0] CH_WR = 2'd0;
   localparam logic [1:0] CH_RD = 2'd1;
   localparam logic [1:0] CH_RR = 2'd2;

   // One stimulus entry
   typedef struct packed
   {
      logic [1:0]    chan;
      emesh_packet_t pkt;
      // Pushed in the same cycle as the next entry
      logic          together;
      logic          rand_wait;
   } stim_t;

   logic                     clk;
   logic                     nreset;
   logic                     txwr_access;
   emesh_packet_t            txwr_packet;
   logic                     txwr_wait;
   logic                     txrd_access;
   emesh_packet_t            txrd_packet;
   logic                     txrd_wait;
   logic                     txrr_access;
   emesh_packet_t            txrr_packet;
   logic                     txrr_wait;
   logic                     etx_wait;
   logic                     etx_access;
   emesh_packet_t            etx_packet;
   cfg_word_t [CFG_REGS-1:0] cfg_words;

   // Stimulus table and scoreboards
   stim_t         stim_tab [$];
   emesh_packet_t exp_q [3][$];
   emesh_packet_t link_log [$];
   cfg_word_t     cfg_model [CFG_REGS];
   int            wait_mode;
   int            seed;
   int            seq;

   // Monitor history from the previous edge
   logic          mon_armed;
   logic          prev_wait;
   logic          prev_access;
   emesh_packet_t prev_packet;

   etx_top i_etx_top
     (.clk(clk), .nreset(nreset),
      .txwr_access(txwr_access), .txwr_packet(txwr_packet), .txwr_wait(txwr_wait),
      .txrd_access(txrd_access), .txrd_packet(txrd_packet), .txrd_wait(txrd_wait),
      .txrr_access(txrr_access), .txrr_packet(txrr_packet), .txrr_wait(txrr_wait),
      .etx_wait(etx_wait), .etx_access(etx_access), .etx_packet(etx_packet),
      .cfg_words(cfg_words));

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ####################################################################
   // Compare tasks
   // ####################################################################

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_packet(string name, emesh_packet_t got, emesh_packet_t exp);
      if (got !== exp)
         abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_word(string name, cfg_word_t got, cfg_word_t exp);
      if (got !== exp)
         abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_wait(string name, logic got, logic exp);
      if (got !== exp)
         abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
   endtask

   // ####################################################################
   // Helpers
   // ####################################################################

   // Config region is the chip ID in the top address bits
   function automatic logic is_cfg(emesh_packet_t p);
      return (p.dstaddr[AW-1 -: ID_W] == CHIP_ID);
   endfunction

   // Link priority, highest first
   function automatic logic [1:0] prio_chan(int p);
      case (p)
         0: return CH_RR;
         1: return CH_WR;
         default: return CH_RD;
      endcase
   endfunction

   function automatic logic channel_wait(logic [1:0] chan);
      case (chan)
         CH_WR: return txwr_wait;
         CH_RD: return txrd_wait;
         default: return txrr_wait;
      endcase
   endfunction

   task automatic set_access(logic [1:0] chan, logic on, emesh_packet_t pkt);
      case (chan)
         CH_WR:
         begin
            txwr_access = on;
            txwr_packet = pkt;
         end
         CH_RD:
         begin
            txrd_access = on;
            txrd_packet = pkt;
         end
         default:
         begin
            txrr_access = on;
            txrr_packet = pkt;
         end
      endcase
   endtask

   // Reads write nothing, every other channel writes
   task automatic add_entry(logic [1:0] chan, logic [AW-1:0] dst, logic [AW-1:0] data,
                            logic together, logic rand_wait);
      stim_t e;
      e.chan         = chan;
      e.pkt.write    = (chan != CH_RD);
      e.pkt.datamode = 2'b10;
      e.pkt.ctrlmode = 5'h00;
      e.pkt.dstaddr  = dst;
      e.pkt.data     = data;
      e.pkt.srcaddr  = {seq[29:0], chan};
      e.together     = together;
      e.rand_wait    = rand_wait;
      seq = seq + 1;
      stim_tab.push_back(e);
   endtask

   // Next falling edge, link wait driven by the current mode
   task automatic step();
      logic [31:0] rnd;
      @(negedge clk);
      rnd = $random(seed);
      case (wait_mode)
         WAIT_RAND: etx_wait = rnd[0];
         WAIT_HIGH: etx_wait = 1'b1;
         default: etx_wait = 1'b0;
      endcase
   endtask

   // ####################################################################
   // Drive and wait
   // ####################################################################

   // Holds each access until its wait is seen low at a rising edge
   task automatic push_group(int first, int last);
      logic [2:0] pending;
      int         n;
      int         i;
      pending = 3'b000;
      step();
      for (i = first; i <= last; i++)
      begin
         set_access(stim_tab[i].chan, 1'b1, stim_tab[i].pkt);
         pending[stim_tab[i].chan] = 1'b1;
      end
      n = 0;
      while (pending != 3'b000)
      begin
         @(posedge clk);
         for (i = first; i <= last; i++)
         begin
            if (pending[stim_tab[i].chan] && !channel_wait(stim_tab[i].chan))
            begin
               pending[stim_tab[i].chan] = 1'b0;
               if (!is_cfg(stim_tab[i].pkt))
                  exp_q[stim_tab[i].chan].push_back(stim_tab[i].pkt);
               else if (stim_tab[i].pkt.write)
                  cfg_model[stim_tab[i].pkt.dstaddr[CFG_IDX_LSB +: CFG_IDX_W]] =
                     stim_tab[i].pkt.data;
            end
         end
         n = n + 1;
         if (n > TIMEOUT)
            abort_run("a source push was never accepted");
         step();
         for (i = first; i <= last; i++)
            if (!pending[stim_tab[i].chan])
               set_access(stim_tab[i].chan, 1'b0, stim_tab[i].pkt);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
      begin
         step();
         n = n + 1;
         if (n > TIMEOUT)
            abort_run("the link did not deliver every queued packet");
      end
   endtask

   // Empty pipeline, no stall, so the packet is on the link after two edges
   task automatic check_latency(emesh_packet_t pkt);
      @(posedge clk);
      check_wait("etx_access", etx_access, 1'b0);
      step();
      @(posedge clk);
      check_wait("etx_access", etx_access, 1'b1);
      check_packet("etx_packet", etx_packet, pkt);
   endtask

   // Words must match the model for several edges in a row
   task automatic settle_cfg();
      int   n;
      int   stable;
      int   k;
      logic same;
      n = 0;
      stable = 0;
      while (stable < CFG_SETTLE)
      begin
         step();
         same = 1'b1;
         for (k = 0; k < CFG_REGS; k++)
            if (cfg_words[k] !== cfg_model[k])
               same = 1'b0;
         stable = same ? stable + 1 : 0;
         n = n + 1;
         if (n > TIMEOUT)
         begin
            for (k = 0; k < CFG_REGS; k++)
               check_word($sformatf("cfg_words[%0d]", k), cfg_words[k], cfg_model[k]);
            abort_run("the config words never settled");
         end
      end
   endtask

   // Same-cycle pushes leave in priority order
   task automatic check_order(int first, int last);
      emesh_packet_t expect_q [$];
      int            p;
      int            i;
      for (p = 0; p < 3; p++)
         for (i = first; i <= last; i++)
            if (stim_tab[i].chan == prio_chan(p))
               expect_q.push_back(stim_tab[i].pkt);
      if (link_log.size() != expect_q.size())
         abort_run("the link delivered a different number of packets than were pushed");
      for (i = 0; i < expect_q.size(); i++)
         check_packet("etx_packet", link_log[i], expect_q[i]);
   endtask

   task automatic apply_group(int first, int last);
      wait_mode = stim_tab[last].rand_wait ? WAIT_RAND : WAIT_OFF;
      if (!stim_tab[last].rand_wait)
         wait_drain();
      link_log.delete();
      push_group(first, last);
      if (!stim_tab[last].rand_wait)
      begin
         if (first == last && !is_cfg(stim_tab[first].pkt))
            check_latency(stim_tab[first].pkt);
         wait_drain();
         if (first != last)
            check_order(first, last);
         settle_cfg();
      end
   endtask

   // Link stalled, write FIFO fills, then drains in order
   task automatic fill_and_drain();
      int k;
      wait_mode = WAIT_OFF;
      wait_drain();
      wait_mode = WAIT_HIGH;
      for (k = 0; k < FIFO_DEPTH; k++)
      begin
         add_entry(CH_WR, 32'h0000_6000 + k, 32'hF00D_0000 + k, 1'b0, 1'b0);
         push_group(stim_tab.size() - 1, stim_tab.size() - 1);
      end
      @(posedge clk);
      check_wait("txwr_wait", txwr_wait, 1'b1);
      check_wait("etx_access", etx_access, 1'b0);
      wait_mode = WAIT_OFF;
      wait_drain();
   endtask

   // ####################################################################
   // Link monitor
   // ####################################################################

   always @(posedge clk)
   begin
      if (mon_armed)
      begin
         // Stall at the last edge froze the output stage
         if (prev_wait)
         begin
            check_wait("etx_access", etx_access, prev_access);
            check_packet("etx_packet", etx_packet, prev_packet);
         end
         if (etx_access && is_cfg(etx_packet))
            abort_run("a config-region packet reached the link");
         if (etx_access && !etx_wait)
         begin
            if (etx_packet.srcaddr[1:0] == 2'd3 || exp_q[etx_packet.srcaddr[1:0]].size() == 0)
               abort_run("the link sent a packet that no channel was expecting");
            check_packet("etx_packet", etx_packet, exp_q[etx_packet.srcaddr[1:0]].pop_front());
            link_log.push_back(etx_packet);
         end
      end
      prev_wait   = etx_wait;
      prev_access = etx_access;
      prev_packet = etx_packet;
      mon_armed   = nreset;
   end

   // ####################################################################
   // Main sequence
   // ####################################################################

   initial
   begin
      int          i;
      int          k;
      int          first;
      logic [31:0] rnd;
      logic [31:0] rdata;
      logic [1:0]  c;
      seed        = 46;
      seq         = 0;
      wait_mode   = WAIT_OFF;
      mon_armed   = 1'b0;
      prev_wait   = 1'b0;
      prev_access = 1'b0;
      prev_packet = '0;
      nreset      = 1'b0;
      etx_wait    = 1'b0;
      txwr_access = 1'b0;
      txwr_packet = '0;
      txrd_access = 1'b0;
      txrd_packet = '0;
      txrr_access = 1'b0;
      txrr_packet = '0;
      for (k = 0; k < CFG_REGS; k++)
         cfg_model[k] = '0;

      // Single link packet per channel
      add_entry(CH_WR, 32'h0000_1000, 32'hA5A5_0001, 1'b0, 1'b0);
      add_entry(CH_RD, 32'h0000_2000, 32'h0000_3000, 1'b0, 1'b0);
      add_entry(CH_RR, 32'h0000_4000, 32'hC3C3_0003, 1'b0, 1'b0);
      // Config writes and a config read
      add_entry(CH_WR, {CHIP_ID, 20'h0000C}, 32'h1111_2222, 1'b0, 1'b0);
      add_entry(CH_WR, {CHIP_ID, 20'h00004}, 32'h3333_4444, 1'b0, 1'b0);
      add_entry(CH_RD, {CHIP_ID, 20'h00004}, 32'h0000_5000, 1'b0, 1'b0);
      add_entry(CH_WR, {CHIP_ID, 20'h00008}, 32'h5555_6666, 1'b0, 1'b0);
      // All three in one cycle
      add_entry(CH_RD, 32'h0000_2010, 32'h0000_3010, 1'b1, 1'b0);
      add_entry(CH_WR, 32'h0000_1010, 32'hA5A5_0011, 1'b1, 1'b0);
      add_entry(CH_RR, 32'h0000_4010, 32'hC3C3_0013, 1'b0, 1'b0);
      // Long mixed run under random link wait
      for (k = 0; k < 40; k++)
      begin
         rnd   = $random(seed);
         rdata = $random(seed);
         c     = rnd[1:0];
         if (c == 2'd3)
            c = CH_RR;
         add_entry(c, {12'h020, rnd[19:0]}, rdata, 1'b0, 1'b1);
      end

      repeat (10) @(posedge clk);
      @(negedge clk);

      // Idle outputs and cleared words while still in reset
      check_wait("etx_access", etx_access, 1'b0);
      check_wait("txwr_wait", txwr_wait, 1'b0);
      check_wait("txrd_wait", txrd_wait, 1'b0);
      check_wait("txrr_wait", txrr_wait, 1'b0);
      for (k = 0; k < CFG_REGS; k++)
         check_word($sformatf("cfg_words[%0d]", k), cfg_words[k], '0);

      nreset = 1'b1;

      first = 0;
      for (i = 0; i < stim_tab.size(); i++)
      begin
         if (!stim_tab[i].together)
         begin
            apply_group(first, i);
            first = i + 1;
         end
      end
      wait_mode = WAIT_OFF;
      wait_drain();
      fill_and_drain();
      settle_cfg();

      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- etx_top.f
source/emesh_pkg.sv
source/etx_fifo.sv
source/etx_arbiter.sv
source/etx_cfg_regs.sv
source/etx_top.sv
tests/etx_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the etx_top testbench with Verilator, exit status gives pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
   --top-module etx_top_tb -f etx_top.f -o etx_top_sim &&
./obj_dir/etx_top_sim ||
{ echo "simulation failed"; exit 1; }
